/* vlog.f */
+incdir+test
design/sfp_pkg.sv
design/align_if.sv
design/sum_if.sv
design/bfp_align.sv
design/twiddle_sum.sv
design/sfp_pack.sv
design/dft4_sfp.sv
test/tb_dft4_sfp.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_dft4_sfp
FILELIST   := vlog.f
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := Test OK

SOURCES := $(wildcard design/*.sv) $(wildcard test/*.sv) $(wildcard test/*.svh)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides pass or fail
sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* test/dft4_ref.svh */
// dft4 sfp reference model
`ifndef DFT4_REF_SVH
`define DFT4_REF_SVH

// operand n of group g, same routing as the twiddle table expects
function automatic sfp_t pick_operand(quad_t re, quad_t im, int g, int n);
  sfp_t r;
  sfp_t i;
  r = re[n*sfp_width +: sfp_width];
  i = im[n*sfp_width +: sfp_width];
  case (g)
    0:       return r;
    1:       return i;
    2:       return (n % 2 == 0) ? r : i;
    default: return (n % 2 == 0) ? i : r;
  endcase
endfunction

function automatic sfp_t renormalize(int sum, int blk);
  int mag;
  int lead;
  int e;
  int sig;
  if (sum == 0) begin
    return '0;
  end
  mag  = (sum < 0) ? -sum : sum;
  lead = 0;
  for (int b = 0; b < 31; b++) begin
    if (((mag >> b) & 1) != 0) begin
      lead = b;
    end
  end
  e = blk + lead - (sig_width + guard_bits);
  if (e <= 0) begin
    return '0;  // underflow
  end
  if (e > (1 << exp_width) - 1) begin
    return {sum < 0, {exp_width{1'b1}}, {sig_width{1'b1}}};
  end
  if (lead >= sig_width) begin
    sig = (mag >> (lead - sig_width)) & ((1 << sig_width) - 1);
  end else begin
    sig = (mag << (sig_width - lead)) & ((1 << sig_width) - 1);
  end
  return {sum < 0, e[exp_width-1:0], sig[sig_width-1:0]};
endfunction

// returns {imag quad, real quad}
function automatic logic [2*lanes*sfp_width-1:0] dft4_expected(quad_t re, quad_t im);
  int    blk  [lanes];
  int    term [lanes][lanes];
  quad_t xr;
  quad_t xi;
  sfp_t  op;
  int    e;
  int    mag;
  int    acc;
  int    g;
  for (int k = 0; k < lanes; k++) begin
    blk[k] = 0;
    for (int n = 0; n < lanes; n++) begin
      op = pick_operand(re, im, k, n);
      e  = int'(op[sig_width +: exp_width]);
      if (e > blk[k]) begin
        blk[k] = e;
      end
    end
    for (int n = 0; n < lanes; n++) begin
      op = pick_operand(re, im, k, n);
      e  = int'(op[sig_width +: exp_width]);
      mag = ((1 << sig_width) + int'(op[sig_width-1:0])) << guard_bits;
      mag = (e == 0) ? 0 : mag >> (blk[k] - e);
      term[k][n] = op[sfp_width-1] ? -mag : mag;
    end
  end
  for (int c = 0; c < 2*lanes; c++) begin
    g   = group_of[c];
    acc = 0;
    for (int n = 0; n < lanes; n++) begin
      acc = twiddle_sign[c][n] ? acc - term[g][n] : acc + term[g][n];
    end
    if (c < lanes) begin
      xr[c*sfp_width +: sfp_width] = renormalize(acc, blk[g]);
    end else begin
      xi[(c-lanes)*sfp_width +: sfp_width] = renormalize(acc, blk[g]);
    end
  end
  return {xi, xr};
endfunction

`endif

/* test/tb_dft4_sfp.sv */
// dft4 sfp testbench
`timescale 1ns/1ps

module tb_dft4_sfp import sfp_pkg::*; ();

  localparam int guard_bits     = 2;
  localparam int half_period    = 50;
  localparam int reset_cycles   = 16;
  localparam int drive_delay    = 1;
  localparam int impulse_starts = 4;
  localparam int gap_starts     = 20;
  localparam int rand_cycles    = 200;
  localparam int corner_starts  = 8;
  localparam int n_starts       = impulse_starts + gap_starts + rand_cycles + corner_starts;

  logic  clk;
  logic  rst;
  logic  start;
  quad_t in_real;
  quad_t in_imag;
  quad_t out_real;
  quad_t out_imag;
  logic  done;

  quad_t      exp_real_q [$];
  quad_t      exp_imag_q [$];
  quad_t      held_real = '0;
  quad_t      held_imag = '0;
  logic [2:0] start_pipe;  // start as sampled, one bit per edge
  int         seed;
  int         errors = 0;
  int         checks = 0;

  `include "dft4_ref.svh"

  dft4_sfp #(
    .guard_bits(guard_bits)
  ) u_dut (
    .clk      (clk),
    .rst      (rst),
    .start    (start),
    .in_real  (in_real),
    .in_imag  (in_imag),
    .out_real (out_real),
    .out_imag (out_imag),
    .done     (done)
  );

  always #half_period clk = ~clk;

  function automatic quad_t make_quad(sfp_t x0, sfp_t x1, sfp_t x2, sfp_t x3);
    return {x3, x2, x1, x0};
  endfunction

  function automatic quad_t random_quad();
    quad_t q;
    for (int n = 0; n < lanes; n++) begin
      q[n*sfp_width +: sfp_width] = sfp_t'($random(seed));
    end
    return q;
  endfunction

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      #drive_delay;
    end
  endtask

  // one start, expected result queued at the same time
  task automatic send(input quad_t re, input quad_t im);
    logic [2*lanes*sfp_width-1:0] x;
    x       = dft4_expected(re, im);
    start   = 1'b1;
    in_real = re;
    in_imag = im;
    exp_real_q.push_back(x[lanes*sfp_width-1:0]);
    exp_imag_q.push_back(x[2*lanes*sfp_width-1:lanes*sfp_width]);
    @(posedge clk);
    #drive_delay;
    start = 1'b0;
  endtask

  task automatic compare_result();
    quad_t want_r;
    quad_t want_i;
    if (exp_real_q.size() == 0) begin
      errors++;
      $display("done pulse at %0t arrived with no result expected", $time);
    end else begin
      want_r = exp_real_q.pop_front();
      want_i = exp_imag_q.pop_front();
      checks++;
      assert (out_real == want_r) else begin
        errors++;
        $display("ERROR %0t out_real expected %h got %h", $time, want_r, out_real);
      end
      assert (out_imag == want_i) else begin
        errors++;
        $display("ERROR %0t out_imag expected %h got %h", $time, want_i, out_imag);
      end
      held_real = want_r;
      held_imag = want_i;
    end
  endtask

  task automatic check_hold();
    assert (out_real == held_real) else begin
      errors++;
      $display("ERROR %0t out_real expected %h got %h", $time, held_real, out_real);
    end
    assert (out_imag == held_imag) else begin
      errors++;
      $display("ERROR %0t out_imag expected %h got %h", $time, held_imag, out_imag);
    end
  endtask

  always @(posedge clk or negedge rst) begin
    if (!rst) begin
      start_pipe <= '0;
    end else begin
      start_pipe <= {start_pipe[1:0], start};
    end
  end

  // outputs are sampled mid cycle
  always @(negedge clk) begin
    if (rst) begin
      assert (done == start_pipe[2]) else begin
        errors++;
        $display("ERROR %0t done expected %b got %b", $time, start_pipe[2], done);
      end
      if (done) begin
        compare_result();
      end else begin
        check_hold();
      end
    end
  end

  initial begin
    int gap;
    seed    = 32'hcf4d;
    clk     = 1'b0;
    rst     = 1'b0;
    start   = 1'b0;
    in_real = '0;
    in_imag = '0;
    repeat (reset_cycles) @(posedge clk);
    #drive_delay rst = 1'b1;
    idle(5);  // quiet after reset

    // impulse in x0 real
    send(make_quad(9'h05a, '0, '0, '0), '0);
    send(make_quad(9'h1f3, '0, '0, '0), '0);
    idle(2);
    send(make_quad(9'h010, '0, '0, '0), '0);
    idle(4);
    send(make_quad(9'h0c7, '0, '0, '0), '0);
    idle(4);

    for (int i = 0; i < gap_starts; i++) begin
      send(random_quad(), random_quad());
      gap = $random(seed) & 7;
      idle(gap);
    end

    for (int i = 0; i < rand_cycles; i++) begin
      send(random_quad(), random_quad());
    end
    idle(3);

    // zeros, cancellation and underflow
    send('0, '0);
    send(make_quad(9'h105, 9'h00f, 9'h10a, 9'h003), make_quad(9'h00c, 9'h101, 9'h000, 9'h109));
    send(make_quad(9'h0a3, '0, 9'h0a3, '0), '0);
    send(make_quad(9'h0a3, 9'h14e, 9'h0a3, 9'h14e), make_quad(9'h066, '0, 9'h066, '0));
    send(make_quad(9'h010, 9'h011, 9'h010, 9'h011), '0);
    send(make_quad(9'h020, 9'h120, 9'h021, 9'h121), make_quad(9'h011, 9'h010, '0, '0));

    // saturation
    send(make_quad(9'h0ff, 9'h0ff, 9'h0ff, 9'h0ff), make_quad(9'h0ff, 9'h0ff, 9'h0ff, 9'h0ff));
    send(make_quad(9'h1ff, 9'h1ff, 9'h1ff, 9'h1ff), make_quad(9'h1f8, 9'h1f8, 9'h1f8, 9'h1f8));

    while (exp_real_q.size() != 0) begin
      idle(1);
    end
    idle(8);  // nothing extra may show up

    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  initial begin
    #((n_starts + reset_cycles) * 10 * 2 * half_period);
    $display("timeout, the results did not all arrive in time");
    $display("Test FAILED");
    $finish;
  end

endmodule

/* design/dft4_sfp.sv */
// 4-point block floating point dft
`timescale 1ns/1ps

module dft4_sfp import sfp_pkg::*; #(
  parameter int guard_bits = 2
) (
  input  logic  clk,
  input  logic  rst,
  input  logic  start,
  input  quad_t in_real,
  input  quad_t in_imag,
  output quad_t out_real,
  output quad_t out_imag,
  output logic  done
);

  align_if #(
    .guard_bits(guard_bits)
  ) align_bus ();

  sum_if #(
    .guard_bits(guard_bits)
  ) sum_bus ();

  // decode, one cycle
  bfp_align #(
    .guard_bits(guard_bits)
  ) u_align (
    .clk     (clk),
    .rst     (rst),
    .start   (start),
    .in_real (in_real),
    .in_imag (in_imag),
    .aligned (align_bus.stage)
  );

  // execute, one cycle
  twiddle_sum #(
    .guard_bits(guard_bits)
  ) u_sum (
    .clk     (clk),
    .rst     (rst),
    .aligned (align_bus.sink),
    .sums    (sum_bus.stage)
  );

  // result, one cycle
  sfp_pack #(
    .guard_bits(guard_bits)
  ) u_pack (
    .clk      (clk),
    .rst      (rst),
    .sums     (sum_bus.sink),
    .out_real (out_real),
    .out_imag (out_imag),
    .done     (done)
  );

endmodule

/* design/sfp_pack.sv */
// renormalize sums into sfp and register outputs
`timescale 1ns/1ps

module sfp_pack import sfp_pkg::*; #(
  parameter int guard_bits = 2
) (
  input  logic  clk,
  input  logic  rst,
  sum_if.sink   sums,
  output quad_t out_real,
  output quad_t out_imag,
  output logic  done
);

  localparam int term_w  = sig_width + 4 + guard_bits;
  localparam int outs    = 2 * lanes;
  localparam int exp_max = (1 << exp_width) - 1;

  sfp_t res [outs];

  always_comb begin
    logic [term_w-1:0] mag;
    logic [term_w-1:0] norm;
    logic              neg;
    int                lead;
    int                e_full;
    sig_t              sig;
    for (int c = 0; c < outs; c++) begin
      neg  = sums.sum[c][term_w-1];
      mag  = neg ? -sums.sum[c] : sums.sum[c];
      lead = 0;
      for (int b = 0; b < term_w; b++) begin
        if (mag[b]) begin
          lead = b;
        end
      end
      // four bits under the leading one, zero filled when lead is small
      norm   = mag << (term_w - 1 - lead);
      sig    = norm[term_w-2 -: sig_width];
      e_full = int'(sums.blk_exp[group_of[c]]) + lead - (sig_width + guard_bits);
      if (mag == '0 || e_full <= 0) begin
        res[c] = '0;  // zero or underflow
      end else if (e_full > exp_max) begin
        res[c] = {neg, {exp_width{1'b1}}, {sig_width{1'b1}}};
      end else begin
        res[c] = {neg, exp_t'(e_full), sig};
      end
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      out_real <= '0;
      out_imag <= '0;
      done     <= 1'b0;
    end else begin
      done <= sums.valid;
      if (sums.valid) begin
        for (int n = 0; n < lanes; n++) begin
          out_real[n*sfp_width +: sfp_width] <= res[n];
          out_imag[n*sfp_width +: sfp_width] <= res[lanes+n];
        end
      end
    end
  end

  a_done_known : assert property (@(posedge clk) disable iff (!rst)
    !$isunknown(done));

  for (genvar n = 0; n < lanes; n++) begin : g_chk
    a_real_norm : assert property (@(posedge clk) disable iff (!rst)
      out_real[n*sfp_width +: sfp_width] != '0 |->
        out_real[n*sfp_width + sig_width +: exp_width] != '0);
    a_imag_norm : assert property (@(posedge clk) disable iff (!rst)
      out_imag[n*sfp_width +: sfp_width] != '0 |->
        out_imag[n*sfp_width + sig_width +: exp_width] != '0);
  end

endmodule

/* design/twiddle_sum.sv */
// twiddle signs and four-term sums
`timescale 1ns/1ps

module twiddle_sum import sfp_pkg::*; #(
  parameter int guard_bits = 2
) (
  input  logic  clk,
  input  logic  rst,
  align_if.sink aligned,
  sum_if.stage  sums
);

  localparam int term_w = sig_width + 4 + guard_bits;
  localparam int outs   = 2 * lanes;

  logic signed [term_w-1:0] sum_d [outs];

  // term_w leaves two bits of headroom, so four terms never overflow
  always_comb begin
    logic signed [term_w-1:0] t;
    logic signed [term_w-1:0] acc;
    for (int c = 0; c < outs; c++) begin
      acc = '0;
      for (int n = 0; n < lanes; n++) begin
        t   = aligned.term[group_of[c]][n];
        acc = acc + (twiddle_sign[c][n] ? -t : t);
      end
      sum_d[c] = acc;
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      sums.valid <= 1'b0;
    end else begin
      sums.valid <= aligned.valid;
    end
  end

  always_ff @(posedge clk) begin
    sums.sum     <= sum_d;
    sums.blk_exp <= aligned.blk_exp;  // carried with the data
  end

  // x0 plus x2 real cancels terms 1 and 3 of group 0
  a_pair_sum : assert property (@(posedge clk) disable iff (!rst)
    aligned.valid |-> sum_d[0] + sum_d[2] ==
      2 * (aligned.term[0][0] + aligned.term[0][2]));

endmodule

/* design/bfp_align.sv */
// block exponent and significand alignment
`timescale 1ns/1ps

module bfp_align import sfp_pkg::*; #(
  parameter int guard_bits = 2
) (
  input  logic   clk,
  input  logic   rst,
  input  logic   start,
  input  quad_t  in_real,
  input  quad_t  in_imag,
  align_if.stage aligned
);

  localparam int term_w = sig_width + 4 + guard_bits;
  localparam int mag_w  = sig_width + 1 + guard_bits;  // hidden one plus guard

  sfp_t                     op      [lanes][lanes];  // [group][term]
  exp_t                     op_exp  [lanes][lanes];
  exp_t                     blk_exp [lanes];
  logic signed [term_w-1:0] term    [lanes][lanes];

  // route the eight inputs into the four operand groups
  for (genvar n = 0; n < lanes; n++) begin : g_route
    assign op[0][n] = in_real[n*sfp_width +: sfp_width];
    assign op[1][n] = in_imag[n*sfp_width +: sfp_width];
    if (n % 2 == 0) begin : g_even
      assign op[2][n] = in_real[n*sfp_width +: sfp_width];
      assign op[3][n] = in_imag[n*sfp_width +: sfp_width];
    end else begin : g_odd
      assign op[2][n] = in_imag[n*sfp_width +: sfp_width];
      assign op[3][n] = in_real[n*sfp_width +: sfp_width];
    end
    for (genvar g = 0; g < lanes; g++) begin : g_exp
      assign op_exp[g][n] = op[g][n][sig_width +: exp_width];
    end
  end

  // largest exponent per group
  always_comb begin
    for (int g = 0; g < lanes; g++) begin
      blk_exp[g] = '0;
      for (int n = 0; n < lanes; n++) begin
        if (op_exp[g][n] > blk_exp[g]) begin
          blk_exp[g] = op_exp[g][n];
        end
      end
    end
  end

  always_comb begin
    exp_t                     diff;
    logic [mag_w-1:0]         mag;
    logic signed [term_w-1:0] t;
    for (int g = 0; g < lanes; g++) begin
      for (int n = 0; n < lanes; n++) begin
        diff = blk_exp[g] - op_exp[g][n];
        mag  = (mag_w'({1'b1, op[g][n][sig_width-1:0]}) << guard_bits) >> diff;
        if (op_exp[g][n] == '0) begin
          mag = '0;  // zero operand
        end
        t = {{(term_w-mag_w){1'b0}}, mag};
        term[g][n] = op[g][n][sfp_width-1] ? -t : t;
      end
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      aligned.valid <= 1'b0;
    end else begin
      aligned.valid <= start;
    end
  end

  // payload, qualified by valid
  always_ff @(posedge clk) begin
    aligned.blk_exp <= blk_exp;
    aligned.term    <= term;
  end

  for (genvar g = 0; g < lanes; g++) begin : g_chk
    for (genvar n = 0; n < lanes; n++) begin : g_op
      a_blk_exp_max : assert property (@(posedge clk) disable iff (!rst)
        aligned.valid |-> aligned.blk_exp[g] >= $past(op_exp[g][n]));
    end
  end

endmodule

/* design/sum_if.sv */
// signed sums, execute to result
`timescale 1ns/1ps

interface sum_if import sfp_pkg::*; #(
  parameter int guard_bits = 2
) ();

  localparam int term_w = sig_width + 4 + guard_bits;

  logic                     valid;
  exp_t                     blk_exp [lanes];
  logic signed [term_w-1:0] sum     [2*lanes];  // X0..X3 real, then imag

  modport stage (
    output valid,
    output blk_exp,
    output sum
  );

  modport sink (
    input valid,
    input blk_exp,
    input sum
  );

endinterface

/* design/align_if.sv */
// aligned group terms, decode to execute
`timescale 1ns/1ps

interface align_if import sfp_pkg::*; #(
  parameter int guard_bits = 2
) ();

  localparam int term_w = sig_width + 4 + guard_bits;

  logic                     valid;
  exp_t                     blk_exp [lanes];         // one per operand group
  logic signed [term_w-1:0] term    [lanes][lanes];  // [group][term]

  modport stage (
    output valid,
    output blk_exp,
    output term
  );

  modport sink (
    input valid,
    input blk_exp,
    input term
  );

endinterface

/* design/sfp_pkg.sv */
// sfp format and dft4 tables
package sfp_pkg;

  localparam int exp_width = 4;
  localparam int sig_width = 4;
  localparam int sfp_width = 1 + exp_width + sig_width;  // sign, exponent, significand
  localparam int lanes     = 4;

  typedef logic [exp_width-1:0]       exp_t;
  typedef logic [sig_width-1:0]       sig_t;
  typedef logic [sfp_width-1:0]       sfp_t;
  typedef logic [lanes*sfp_width-1:0] quad_t;  // element 0 in the low bits

  // output components 0..3 are X0..X3 real, 4..7 are X0..X3 imag
  // bit n set means term n of the group is subtracted
  localparam logic [lanes-1:0] twiddle_sign [2*lanes] = '{
    4'b0000,  // X0 real  r0 + r1 + r2 + r3
    4'b1100,  // X1 real  r0 + i1 - r2 - i3
    4'b1010,  // X2 real  r0 - r1 + r2 - r3
    4'b0110,  // X3 real  r0 - i1 - r2 + i3
    4'b0000,  // X0 imag
    4'b0110,  // X1 imag  i0 - r1 - i2 + r3
    4'b1010,  // X2 imag
    4'b1100   // X3 imag  i0 + r1 - i2 - r3
  };

  // operand groups
  //   0: r0 r1 r2 r3
  //   1: i0 i1 i2 i3
  //   2: r0 i1 r2 i3
  //   3: i0 r1 i2 r3
  localparam int group_of [2*lanes] = '{0, 2, 0, 2, 1, 3, 1, 3};

endpackage
